//--- all.f
aes_pkg.sv
aes_stream_pkg.sv
aes_cbc_loader.sv
aes_key_schedule.sv
aes_cbc_cipher.sv
aes256_cbc_top.sv
tb_aes_cbc.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_aes_cbc -f all.f \
    && ./obj_dir/Vtb_aes_cbc | tee sim.log \
    && grep -qF "*** TEST PASSED ***" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb_aes_cbc.sv
`timescale 1ns/1ps

module tb_aes_cbc;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int EXP_LATENCY    = 15;

    // Keys are {high beat, low beat} and the low beat goes first on the stream
    localparam aes_pkg::key_t FIPS_KEY = {128'h101112131415161718191a1b1c1d1e1f,
                                          128'h000102030405060708090a0b0c0d0e0f};
    localparam aes_pkg::block_t FIPS_PT = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::block_t FIPS_CT = 128'h8ea2b7ca516745bfeafc49904b496089;

    localparam aes_pkg::key_t SP_KEY = {128'h1f352c073b6108d72d9810a30914dff4,
                                        128'h603deb1015ca71be2b73aef0857d7781};
    localparam aes_pkg::block_t SP_IV  = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::block_t SP_PT1 = 128'h6bc1bee22e409f96e93d7e117393172a;
    localparam aes_pkg::block_t SP_PT2 = 128'hae2d8a571e03ac9c9eb76fac45af8e51;
    localparam aes_pkg::block_t SP_CT1 = 128'hf58c4c04d6e5f1ba779eabfb5f7bfbd6;
    localparam aes_pkg::block_t SP_CT2 = 128'h9cfc4e967edb808d679f777bc6702c7d;

    logic                       Clk;
    logic                       arst_n;
    aes_stream_pkg::axis_beat_t s_beat;
    logic                       s_tvalid;
    logic                       s_tready;
    aes_stream_pkg::axis_beat_t m_beat;
    logic                       m_tvalid;
    logic                       m_tready;
    int                         cycle_cnt = 0;
    int                         accept_cyc;
    integer                     seed;

    aes256_cbc_top dut0 (
        .Clk      (Clk),
        .arst_n   (arst_n),
        .s_beat   (s_beat),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_beat   (m_beat),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge Clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles, the DUT stopped responding",
                                     cycle_cnt));
        end
    end

    task automatic compare_block(input string name, input aes_pkg::block_t got,
                                 input aes_pkg::block_t exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_keep(input string name,
                                input logic [aes_stream_pkg::KEEP_BITS-1:0] got,
                                input logic [aes_stream_pkg::KEEP_BITS-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("CHECK FAILED %s: got %0h, expected %0h", name, got, exp));
        end
    endtask

    // Holds the beat until the loader takes it, then records the accepting edge
    task automatic send_beat(input aes_pkg::block_t data, input logic last);
        @(negedge Clk);
        s_beat.tdata = data;
        s_beat.tkeep = '1;
        s_beat.tlast = last;
        s_tvalid     = 1'b1;
        while (!s_tready) @(negedge Clk);
        @(posedge Clk);
        @(negedge Clk);
        accept_cyc = cycle_cnt;
        s_tvalid   = 1'b0;
    endtask

    task automatic expect_block(input aes_pkg::block_t exp, input logic last,
                                input logic stall, input logic check_latency);
        logic [31:0] rand_word;
        logic        done;
        int          polls;
        done  = 1'b0;
        polls = 0;
        while (!m_tvalid) @(negedge Clk);
        if (check_latency) begin
            compare_count("accept to m_tvalid latency", cycle_cnt + 1 - accept_cyc, EXP_LATENCY);
        end
        while (!done) begin
            compare_flag("m_tvalid", m_tvalid, 1'b1);
            compare_block("m_beat.tdata", m_beat.tdata, exp);
            compare_keep("m_beat.tkeep", m_beat.tkeep, '1);
            compare_flag("m_beat.tlast", m_beat.tlast, last);
            compare_flag("s_tready", s_tready, 1'b0);
            if (stall) begin
                rand_word = $random(seed);
                // The first look always stalls and later ones follow the random pattern
                m_tready  = rand_word[0] & (polls > 0);
            end
            polls++;
            @(posedge Clk);
            done = m_tready;
            @(negedge Clk);
        end
        if (stall) m_tready = 1'b0;
        compare_flag("m_tvalid", m_tvalid, 1'b0);
    endtask

    task automatic load_session(input aes_pkg::key_t key, input aes_pkg::block_t iv);
        send_beat(key[127:0], 1'b0);
        send_beat(key[255:128], 1'b0);
        send_beat(iv, 1'b0);
    endtask

    task automatic encrypt_block(input aes_pkg::block_t pt, input aes_pkg::block_t exp,
                                 input logic last, input logic stall, input logic lat);
        send_beat(pt, last);
        expect_block(exp, last, stall, lat);
    endtask

    task automatic run_cbc_chain(input logic stall);
        load_session(SP_KEY, SP_IV);
        encrypt_block(SP_PT1, SP_CT1, 1'b0, stall, 1'b0);
        encrypt_block(SP_PT2, SP_CT2, 1'b1, stall, 1'b0);
    endtask

    initial begin
        seed     = 32'h6371_12b9;
        arst_n   = 1'b0;
        s_beat   = '0;
        s_tvalid = 1'b0;
        m_tready = 1'b1;
        repeat (16) @(posedge Clk);
        @(negedge Clk);
        arst_n = 1'b1;
        compare_flag("s_tready", s_tready, 1'b0);
        compare_flag("m_tvalid", m_tvalid, 1'b0);
        @(negedge Clk);
        compare_flag("s_tready", s_tready, 1'b1);

        load_session(FIPS_KEY, '0);
        encrypt_block(FIPS_PT, FIPS_CT, 1'b1, 1'b0, 1'b0);
        $display("FIPS-197 single block done");

        run_cbc_chain(1'b0);
        $display("CBC two-block chain done");

        load_session(FIPS_KEY, '0);
        encrypt_block(FIPS_PT, FIPS_CT, 1'b1, 1'b0, 1'b1);
        $display("Fixed latency done");

        m_tready = 1'b0;
        run_cbc_chain(1'b1);
        m_tready = 1'b1;
        $display("Back-pressure done");

        load_session(FIPS_KEY, '0);
        encrypt_block(FIPS_PT, FIPS_CT, 1'b1, 1'b0, 1'b0);
        $display("New session after tlast done");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- aes256_cbc_top.sv
`timescale 1ns/1ps

module aes256_cbc_top (
    input  logic                       Clk,
    input  logic                       arst_n,
    input  aes_stream_pkg::axis_beat_t s_beat,
    input  logic                       s_tvalid,
    output logic                       s_tready,
    output aes_stream_pkg::axis_beat_t m_beat,
    output logic                       m_tvalid,
    input  logic                       m_tready
);

    aes_stream_pkg::key_load_t key_load;
    aes_stream_pkg::text_req_t text_req;
    aes_pkg::round_idx_t       round_idx;
    aes_pkg::block_t           round_key;
    logic                      keys_ready;
    logic                      busy;

    aes_cbc_loader loader0 (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .s_beat    (s_beat),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .key_ready (keys_ready),
        .busy      (busy),
        .key_load  (key_load),
        .text_req  (text_req)
    );

    aes_key_schedule sched0 (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .key_load   (key_load),
        .round_idx  (round_idx),
        .round_key  (round_key),
        .keys_ready (keys_ready)
    );

    aes_cbc_cipher cipher0 (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .text_req  (text_req),
        .round_key (round_key),
        .round_idx (round_idx),
        .busy      (busy),
        .m_beat    (m_beat),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready)
    );

endmodule

//--- aes_cbc_cipher.sv
`timescale 1ns/1ps

module aes_cbc_cipher (
    input  logic                       Clk,
    input  logic                       arst_n,
    input  aes_stream_pkg::text_req_t  text_req,
    input  aes_pkg::block_t            round_key,
    output aes_pkg::round_idx_t        round_idx,
    output logic                       busy,
    output aes_stream_pkg::axis_beat_t m_beat,
    output logic                       m_tvalid,
    input  logic                       m_tready
);

    aes_pkg::block_t     chain_q;
    aes_pkg::block_t     state_q;
    aes_pkg::round_idx_t rnd_q;
    logic                busy_q;
    logic                out_valid_q;
    logic                out_last_q;
    logic                start;
    logic                running;
    logic                out_fire;
    logic                last_round;

    assign start      = text_req.valid & ~text_req.iv_load;
    assign running    = busy_q & ~out_valid_q;
    assign out_fire   = out_valid_q & m_tready;
    assign last_round = (rnd_q == aes_pkg::NUM_ROUNDS);

    // rnd_q rests at zero so round key 0 is on hand when a block arrives
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q      <= 1'b0;
            out_valid_q <= 1'b0;
            rnd_q       <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            rnd_q  <= 4'd1;
        end else if (running) begin
            if (last_round) begin
                out_valid_q <= 1'b1;
                rnd_q       <= '0;
            end else begin
                rnd_q <= rnd_q + 4'd1;
            end
        end else if (out_fire) begin
            busy_q      <= 1'b0;
            out_valid_q <= 1'b0;
        end
    end

    // Chaining value is the IV for the first block, then the previous ciphertext
    always_ff @(posedge Clk) begin
        if (text_req.valid && text_req.iv_load) begin
            chain_q <= text_req.data;
        end else if (out_fire) begin
            chain_q <= state_q;
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            state_q    <= text_req.data ^ chain_q ^ round_key;
            out_last_q <= text_req.last;
        end else if (running) begin
            state_q <= aes_pkg::enc_round(state_q, round_key, last_round);
        end
    end

    assign round_idx    = rnd_q;
    assign busy         = busy_q;
    assign m_tvalid     = out_valid_q;
    assign m_beat.tdata = state_q;
    assign m_beat.tkeep = '1;
    assign m_beat.tlast = out_last_q;

endmodule

//--- aes_key_schedule.sv
`timescale 1ns/1ps

module aes_key_schedule (
    input  logic                      Clk,
    input  logic                      arst_n,
    input  aes_stream_pkg::key_load_t key_load,
    input  aes_pkg::round_idx_t       round_idx,
    output aes_pkg::block_t           round_key,
    output logic                      keys_ready
);

    aes_pkg::block_t     rk_mem [aes_pkg::NUM_ROUNDS+1];
    aes_pkg::block_t     prev_lo_q;
    aes_pkg::block_t     prev_hi_q;
    aes_pkg::block_t     next_key;
    aes_pkg::round_idx_t gen_idx_q;
    logic                gen_active_q;
    logic                ready_q;
    logic [31:0]         temp_word;
    logic [31:0]         w0, w1, w2, w3;
    logic [7:0]          rcon;

    // Round key r comes from keys r-2 and r-1, rcon steps once per even key
    always_comb begin
        rcon = 8'h01 << (gen_idx_q[3:1] - 3'd1);
        if (!gen_idx_q[0]) begin
            temp_word = aes_pkg::sub_word(aes_pkg::rot_word(prev_hi_q[31:0])) ^ {rcon, 24'h0};
        end else begin
            temp_word = aes_pkg::sub_word(prev_hi_q[31:0]);
        end
        w0       = prev_lo_q[127:96] ^ temp_word;
        w1       = prev_lo_q[95:64] ^ w0;
        w2       = prev_lo_q[63:32] ^ w1;
        w3       = prev_lo_q[31:0] ^ w2;
        next_key = {w0, w1, w2, w3};
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            gen_active_q <= 1'b0;
            gen_idx_q    <= '0;
            ready_q      <= 1'b0;
        end else if (key_load.valid) begin
            gen_active_q <= 1'b1;
            gen_idx_q    <= 4'd2;
            ready_q      <= 1'b0;
        end else if (gen_active_q) begin
            gen_idx_q <= gen_idx_q + 4'd1;
            if (gen_idx_q == aes_pkg::NUM_ROUNDS) begin
                gen_active_q <= 1'b0;
                ready_q      <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (key_load.valid) begin
            rk_mem[0] <= key_load.key[127:0];
            rk_mem[1] <= key_load.key[255:128];
            prev_lo_q <= key_load.key[127:0];
            prev_hi_q <= key_load.key[255:128];
        end else if (gen_active_q) begin
            rk_mem[gen_idx_q] <= next_key;
            prev_lo_q         <= prev_hi_q;
            prev_hi_q         <= next_key;
        end
    end

    assign round_key  = rk_mem[round_idx];
    assign keys_ready = ready_q;

endmodule

//--- aes_cbc_loader.sv
`timescale 1ns/1ps

module aes_cbc_loader (
    input  logic                       Clk,
    input  logic                       arst_n,
    input  aes_stream_pkg::axis_beat_t s_beat,
    input  logic                       s_tvalid,
    output logic                       s_tready,
    input  logic                       key_ready,
    input  logic                       busy,
    output aes_stream_pkg::key_load_t  key_load,
    output aes_stream_pkg::text_req_t  text_req
);

    aes_stream_pkg::load_state_e state_q;
    aes_stream_pkg::load_state_e state_d;
    aes_pkg::block_t             key_lo_q;
    aes_pkg::key_t               key_q;
    logic                        key_valid_q;
    logic                        accept;

    assign accept = s_tvalid & s_tready;

    always_comb begin
        case (state_q)
            aes_stream_pkg::LD_KEY_LO,
            aes_stream_pkg::LD_KEY_HI,
            aes_stream_pkg::LD_IV:   s_tready = 1'b1;
            // One block in flight, and only once the round keys exist
            aes_stream_pkg::LD_TEXT: s_tready = key_ready & ~busy;
            default:                 s_tready = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            aes_stream_pkg::LD_KEY_LO: begin
                if (accept) state_d = aes_stream_pkg::LD_KEY_HI;
            end
            aes_stream_pkg::LD_KEY_HI: begin
                if (accept) state_d = aes_stream_pkg::LD_IV;
            end
            aes_stream_pkg::LD_IV: begin
                if (accept) state_d = aes_stream_pkg::LD_TEXT;
            end
            aes_stream_pkg::LD_TEXT: begin
                if (accept && s_beat.tlast) state_d = aes_stream_pkg::LD_WAIT;
            end
            // Let the last block drain before a new key can touch the schedule
            aes_stream_pkg::LD_WAIT: begin
                if (!busy) state_d = aes_stream_pkg::LD_KEY_LO;
            end
            default: state_d = aes_stream_pkg::LD_WAIT;
        endcase
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= aes_stream_pkg::LD_WAIT;
            key_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            key_valid_q <= accept & (state_q == aes_stream_pkg::LD_KEY_HI);
        end
    end

    always_ff @(posedge Clk) begin
        if (accept && state_q == aes_stream_pkg::LD_KEY_LO) begin
            key_lo_q <= s_beat.tdata;
        end
        if (accept && state_q == aes_stream_pkg::LD_KEY_HI) begin
            key_q <= {s_beat.tdata, key_lo_q};
        end
    end

    assign key_load.valid = key_valid_q;
    assign key_load.key   = key_q;

    assign text_req.valid   = accept & (state_q == aes_stream_pkg::LD_IV |
                                        state_q == aes_stream_pkg::LD_TEXT);
    assign text_req.iv_load = (state_q == aes_stream_pkg::LD_IV);
    assign text_req.data    = s_beat.tdata;
    assign text_req.last    = s_beat.tlast;

endmodule

//--- aes_stream_pkg.sv
package aes_stream_pkg;

    localparam int KEEP_BITS = aes_pkg::BLOCK_BITS / 8;

    typedef struct packed {
        aes_pkg::block_t       tdata;
        logic [KEEP_BITS-1:0]  tkeep;
        logic                  tlast;
    } axis_beat_t;

    // Low half of key is round key 0
    typedef struct packed {
        logic          valid;
        aes_pkg::key_t key;
    } key_load_t;

    typedef struct packed {
        logic            valid;
        logic            iv_load;
        aes_pkg::block_t data;
        logic            last;
    } text_req_t;

    typedef enum logic [2:0] {
        LD_KEY_LO,
        LD_KEY_HI,
        LD_IV,
        LD_TEXT,
        LD_WAIT
    } load_state_e;

endpackage

//--- aes_pkg.sv
package aes_pkg;

    localparam int NUM_ROUNDS = 14;
    localparam int BLOCK_BITS = 128;

    // Byte 0 of the block sits in the top byte, column-major as in FIPS-197
    typedef logic [BLOCK_BITS-1:0]   block_t;
    typedef logic [2*BLOCK_BITS-1:0] key_t;
    typedef logic [3:0]              round_idx_t;

    // Forward S-box, one row of sixteen entries per line
    localparam logic [2047:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] sbox(logic [7:0] b);
        return SBOX_TABLE[2047 - 8*int'(b) -: 8];
    endfunction

    function automatic logic [7:0] xtime(logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [31:0] rot_word(logic [31:0] w);
        return {w[23:0], w[31:24]};
    endfunction

    function automatic logic [31:0] sub_word(logic [31:0] w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    function automatic block_t sub_bytes(block_t s);
        block_t o;
        for (int i = 0; i < 16; i++) begin
            o[8*i +: 8] = sbox(s[8*i +: 8]);
        end
        return o;
    endfunction

    // Row r of column c moves to column c - r
    function automatic block_t shift_rows(block_t s);
        block_t o;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                o[BLOCK_BITS-1 - 8*(4*c + r) -: 8] =
                    s[BLOCK_BITS-1 - 8*(4*((c + r) % 4) + r) -: 8];
            end
        end
        return o;
    endfunction

    function automatic block_t mix_columns(block_t s);
        block_t     o;
        logic [7:0] a0, a1, a2, a3;
        for (int c = 0; c < 4; c++) begin
            a0 = s[BLOCK_BITS-1 - 32*c -: 8];
            a1 = s[BLOCK_BITS-9 - 32*c -: 8];
            a2 = s[BLOCK_BITS-17 - 32*c -: 8];
            a3 = s[BLOCK_BITS-25 - 32*c -: 8];
            o[BLOCK_BITS-1 - 32*c -: 8]  = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            o[BLOCK_BITS-9 - 32*c -: 8]  = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            o[BLOCK_BITS-17 - 32*c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            o[BLOCK_BITS-25 - 32*c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
        return o;
    endfunction

    // One forward round, the final round has no MixColumns
    function automatic block_t enc_round(block_t state, block_t key, logic last);
        block_t s;
        s = shift_rows(sub_bytes(state));
        if (!last) begin
            s = mix_columns(s);
        end
        return s ^ key;
    endfunction

endpackage
